/* Bender.yml */
package:
  name: host_link

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/host_link_pkg.sv
      - rtl/cmd_parser.sv
      - rtl/sync_fifo.sv
      - rtl/cmd_executor.sv
      - rtl/rsp_serializer.sv
      - rtl/host_link_top.sv
  - target: simulation
    files:
      - bench/host_link_assert.sv
      - bench/host_link_checker.sv
      - bench/host_link_tb.sv

/* bench/host_link_assert.sv */
/*
 * Host link protocol assertions
 * Checks start pulse width, memory strobe exclusion and
 * transmit stream rules on the top level
 */

module host_link_assert (
    input logic       clk,
    input logic       rst,
    input logic       dsa_start,
    input logic       mem_write_en,
    input logic       mem_read_en,
    input logic       tx_valid,
    input logic       tx_ready,
    input logic [7:0] tx_data
);

    // Number of failed assertions
    int assert_errors = 0;

    start_one_cycle: assert property (@(posedge clk) disable iff (rst)
        dsa_start |=> !dsa_start)
        else begin
            $error("dsa_start stayed high for two cycles");
            assert_errors++;
        end

    strobes_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(mem_write_en && mem_read_en))
        else begin
            $error("memory read and write strobes high together");
            assert_errors++;
        end

    // Stalled byte must stay on the bus unchanged
    tx_held: assert property (@(posedge clk) disable iff (rst)
        (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_data)))
        else begin
            $error("tx byte changed or dropped while stalled");
            assert_errors++;
        end

    tx_quiet_in_reset: assert property (@(posedge clk)
        rst |-> !tx_valid)
        else begin
            $error("tx_valid high during reset");
            assert_errors++;
        end

endmodule

bind host_link_top host_link_assert u_assert (.*);

/* bench/host_link_checker.sv */
/*
 * Host link response checker
 * Compares accepted tx bytes, start pulses and configuration
 * against the expected values of the running test
 */

module host_link_checker
    import host_link_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  tx_data,
    input  logic        tx_valid,
    input  logic        tx_ready,
    input  logic        dsa_start,
    input  img_cfg_t    cfg,
    input  logic        test_start,
    input  int          test_id,
    input  logic [3:0]  exp_len,
    input  logic [63:0] exp_rsp,
    input  logic [1:0]  exp_starts,
    input  img_cfg_t    exp_cfg,
    output logic        done,
    output int          n_pass,
    output int          n_fail,
    output int          n_err
);

    int         got;
    int         starts;
    int         errs;
    int         passed = 0;
    int         failed = 0;
    int         total_err = 0;
    logic [7:0] want;

    assign n_pass = passed;
    assign n_fail = failed;
    assign n_err  = total_err;

    // ========================================================
    // Last byte closes the test
    // ========================================================
    task close_test();
        if (starts != exp_starts) begin
            $display("mismatch at %0t: test %0d saw %0d start pulses, expected %0d",
                     $time, test_id, starts, exp_starts);
            errs++;
        end
        if (cfg !== exp_cfg) begin
            $display("mismatch at %0t: test %0d cfg %0d/%0d/%h/%0b, expected %0d/%0d/%h/%0b",
                     $time, test_id, cfg.width, cfg.height, cfg.scale, cfg.simd,
                     exp_cfg.width, exp_cfg.height, exp_cfg.scale, exp_cfg.simd);
            errs++;
        end
        total_err += errs;
        if (errs == 0) begin
            passed++;
            $display("test %0d passed", test_id);
        end else begin
            failed++;
            $display("test %0d failed with %0d errors", test_id, errs);
        end
        done <= 1'b1;
    endtask

    always @(posedge clk) begin
        if (rst || test_start) begin
            got    = 0;
            starts = 0;
            errs   = 0;
            done  <= 1'b0;
        end
        // Traffic on the first edge of a test still counts toward it
        if (!rst) begin
            if (dsa_start) begin
                starts++;
            end
            if (tx_valid && tx_ready) begin
                if (got >= exp_len) begin
                    $display("unexpected tx byte %02h at %0t after test %0d was complete",
                             tx_data, $time, test_id);
                    total_err++;
                end else begin
                    // Byte 0 sits in the highest used byte of exp_rsp
                    want = exp_rsp[8*(exp_len-1-got) +: 8];
                    if (tx_data !== want) begin
                        $display("mismatch at %0t: test %0d byte %0d is %02h, expected %02h",
                                 $time, test_id, got, tx_data, want);
                        errs++;
                    end
                    got++;
                    if (got == exp_len) begin
                        close_test();
                    end
                end
            end
        end
    end

endmodule

/* bench/host_link_tb.sv */
/*
 * Host link testbench
 * Sends a table of commands, models the external memory,
 * stalls tx at random and reports the checker's results
 */

module host_link_tb
    import host_link_pkg::*;
;

    // Table row with byte 0 of cmd and rsp in the highest used byte
    typedef struct packed {
        logic [3:0]  n_cmd;
        logic [95:0] cmd;
        dsa_status_t status;
        logic [3:0]  n_rsp;
        logic [63:0] rsp;
        logic [1:0]  starts;
        img_cfg_t    cfg;
    } test_t;

    logic        clk;
    logic        rst;
    logic [7:0]  rx_data;
    logic        rx_valid;
    logic        rx_ready;
    logic [7:0]  tx_data;
    logic        tx_valid;
    logic        tx_ready;
    img_cfg_t    cfg;
    dsa_status_t status;
    logic        dsa_start;
    logic        mem_write_en;
    logic        mem_read_en;
    addr_t       mem_addr;
    logic [7:0]  mem_wdata;
    logic [7:0]  mem_rdata;

    test_t       tests[$];
    test_t       cur;
    logic        table_ready = 1'b0;
    logic        test_start;
    int          test_id;
    logic        done;
    int          n_pass;
    int          n_fail;
    int          n_err;
    logic [31:0] lfsr = 32'ha21c;
    logic [7:0]  mem_model [256];

    host_link_top u_dut (
        .clk(clk), .rst(rst), .rx_data(rx_data), .rx_valid(rx_valid), .rx_ready(rx_ready),
        .tx_data(tx_data), .tx_valid(tx_valid), .tx_ready(tx_ready), .cfg(cfg),
        .status(status), .dsa_start(dsa_start), .mem_write_en(mem_write_en),
        .mem_read_en(mem_read_en), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata)
    );

    host_link_checker u_checker (
        .clk(clk), .rst(rst), .tx_data(tx_data), .tx_valid(tx_valid), .tx_ready(tx_ready),
        .dsa_start(dsa_start), .cfg(cfg), .test_start(test_start), .test_id(test_id),
        .exp_len(cur.n_rsp), .exp_rsp(cur.rsp), .exp_starts(cur.starts),
        .exp_cfg(cur.cfg), .done(done), .n_pass(n_pass), .n_fail(n_fail), .n_err(n_err)
    );

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic dsa_status_t status_word(input logic b, input logic r,
                                                input logic [15:0] p);
        dsa_status_t s;
        s.busy     = b;
        s.ready    = r;
        s.progress = p;
        return s;
    endfunction

    task automatic add_test(input int n_cmd, input logic [95:0] cmd, input dsa_status_t st,
                            input int n_rsp, input logic [63:0] rsp, input int starts,
                            input img_cfg_t c);
        test_t t;
        t.n_cmd  = 4'(n_cmd);
        t.cmd    = cmd;
        t.status = st;
        t.n_rsp  = 4'(n_rsp);
        t.rsp    = rsp;
        t.starts = 2'(starts);
        t.cfg    = c;
        tests.push_back(t);
    endtask

    // Starts right after a clock edge and returns on the accepting edge
    task automatic send_byte(input logic [7:0] b);
        rx_data  <= b;
        rx_valid <= 1'b1;
        @(posedge clk);
        while (!rx_ready) begin
            @(posedge clk);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Ready unless both LFSR bits drawn this cycle are zero
    initial begin
        logic bit_a;
        forever begin
            @(posedge clk);
            lfsr = lfsr_step(lfsr);
            bit_a = lfsr[0];
            lfsr = lfsr_step(lfsr);
            tx_ready <= bit_a | lfsr[0];
        end
    end

    // External memory with read data one cycle after the strobe
    always @(posedge clk) begin
        if (mem_write_en) begin
            mem_model[mem_addr[7:0]] <= mem_wdata;
        end
        if (mem_read_en) begin
            mem_rdata <= mem_model[mem_addr[7:0]];
        end
    end

    initial begin
        wait (table_ready);
        repeat (tests.size() * 300 + 100) @(posedge clk);
        $display("timeout: test %0d never received its complete response", test_id);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ========================================================
    // Table, reset and test loop
    // ========================================================
    initial begin
        dsa_status_t idle;
        dsa_status_t busy;
        img_cfg_t    c;
        int          t;
        int          i;

        rst        = 1'b1;
        rx_data    = 8'h00;
        rx_valid   = 1'b0;
        tx_ready   = 1'b0;
        status     = '0;
        mem_rdata  = 8'h00;
        test_start = 1'b0;
        test_id    = 0;
        cur        = '0;
        for (i = 0; i < 256; i++) begin
            mem_model[i] = 8'(i) ^ 8'hA5;
        end

        idle = status_word(1'b0, 1'b1, 16'h1234);
        busy = status_word(1'b1, 1'b0, 16'h1234);
        c    = {16'd512, 16'd512, 8'h80, 1'b0};
        add_test(1, 96'h06, idle, 2, 64'hA002, 0, c);
        c.width = 16'd640;
        add_test(3, 96'h010280, idle, 1, 64'hA0, 0, c);
        c.height = 16'd480;
        add_test(3, 96'h0201E0, idle, 1, 64'hA0, 0, c);
        c.scale = 8'h40;
        add_test(2, 96'h0340, idle, 1, 64'hA0, 0, c);
        c.simd = 1'b1;
        add_test(2, 96'h0401, idle, 1, 64'hA0, 0, c);
        add_test(1, 96'h05, idle, 1, 64'hA0, 1, c);
        add_test(1, 96'h05, busy, 1, 64'hB0, 0, c);
        add_test(4, 96'h12000010, idle, 1, 64'hA0, 0, c);
        add_test(2, 96'h105A, idle, 1, 64'hA0, 0, c);
        add_test(2, 96'h10C3, idle, 1, 64'hA0, 0, c);
        add_test(4, 96'h12000010, idle, 1, 64'hA0, 0, c);
        add_test(1, 96'h11, idle, 2, 64'hA05A, 0, c);
        add_test(1, 96'h11, idle, 2, 64'hA0C3, 0, c);
        add_test(1, 96'h07, idle, 3, 64'hA01234, 0, c);
        add_test(1, 96'h77, idle, 1, 64'hE0, 0, c);
        // Back to back runs
        c.width = 16'd800;
        c.simd  = 1'b0;
        add_test(8, 96'h0006070103200400, idle, 8, 64'hA0A002A01234A0A0, 0, c);
        add_test(12, 96'h120000201011120000201177, idle, 6, 64'hA0A0A0A011E0, 0, c);
        add_test(3, 96'h050005, idle, 3, 64'hA0A0A0, 2, c);
        table_ready = 1'b1;

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        for (t = 0; t < tests.size(); t++) begin
            cur        <= tests[t];
            status     <= tests[t].status;
            test_id    <= t;
            test_start <= 1'b1;
            @(posedge clk);
            test_start <= 1'b0;
            for (i = 0; i < cur.n_cmd; i++) begin
                send_byte(cur.cmd[8*(cur.n_cmd-1-i) +: 8]);
            end
            rx_valid <= 1'b0;
            while (!done) begin
                @(posedge clk);
            end
        end

        // Room for any stray bytes to show up
        repeat (20) @(posedge clk);
        $display("%0d tests: %0d passed, %0d failed, %0d errors, %0d assertion failures",
                 tests.size(), n_pass, n_fail, n_err, u_dut.u_assert.assert_errors);
        if (n_fail == 0 && n_err == 0 && n_pass == tests.size()
            && u_dut.u_assert.assert_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* host_link.f */
+incdir+rtl
rtl/host_link_pkg.sv
rtl/cmd_parser.sv
rtl/sync_fifo.sv
rtl/cmd_executor.sv
rtl/rsp_serializer.sv
rtl/host_link_top.sv
bench/host_link_assert.sv
bench/host_link_checker.sv
bench/host_link_tb.sv

/* rtl/cmd_executor.sv */
/*
 * Command executor
 * Holds the accelerator configuration and memory address,
 * drives start and memory strobes, and builds responses
 */

`include "host_link_config.svh"

module cmd_executor
    import host_link_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  cmd_t        cmd_in,
    input  logic        cmd_empty,
    output logic        cmd_pop,
    input  logic        rsp_full,
    output logic        rsp_push,
    output rsp_t        rsp_out,
    output img_cfg_t    cfg,
    input  dsa_status_t status,
    output logic        dsa_start,
    output logic        mem_write_en,
    output logic        mem_read_en,
    output addr_t       mem_addr,
    output logic [7:0]  mem_wdata,
    input  logic [7:0]  mem_rdata
);

    img_cfg_t    cfg_q;
    addr_t       addr_q;
    logic        wait_rd;
    logic        rd_done;
    logic [23:0] addr_arg;
    rsp_t        cmd_rsp;

    assign cfg      = cfg_q;
    assign mem_addr = addr_q;
    assign addr_arg = {cmd_in.arg[0], cmd_in.arg[1], cmd_in.arg[2]};

    // No pop while a read is outstanding
    assign cmd_pop  = !cmd_empty && !rsp_full && !wait_rd;
    // Read data arrives the cycle after the strobe
    assign rd_done  = wait_rd && !mem_read_en && !rsp_full;
    assign rsp_push = (cmd_pop && cmd_in.opcode != OP_READ_MEM) || rd_done;

    // ========================================================
    // Response for the command at the FIFO head
    // ========================================================
    always_comb begin
        cmd_rsp         = '0;
        cmd_rsp.count   = 2'd1;
        cmd_rsp.data[0] = RSP_OK;
        case (cmd_in.opcode)
            OP_NOP, OP_SET_WIDTH, OP_SET_HEIGHT, OP_SET_SCALE,
            OP_SET_MODE, OP_SET_ADDR, OP_WRITE_MEM, OP_READ_MEM: ;
            OP_START: begin
                if (status.busy) begin
                    cmd_rsp.data[0] = RSP_BUSY;
                end
            end
            OP_GET_STATUS: begin
                cmd_rsp.count   = 2'd2;
                cmd_rsp.data[1] = {6'd0, status.ready, status.busy};
            end
            OP_GET_PROGRESS: begin
                cmd_rsp.count   = 2'd3;
                cmd_rsp.data[1] = status.progress[15:8];
                cmd_rsp.data[2] = status.progress[7:0];
            end
            default: cmd_rsp.data[0] = RSP_ERROR;
        endcase
    end

    always_comb begin
        rsp_out = cmd_rsp;
        if (wait_rd) begin
            rsp_out         = '0;
            rsp_out.count   = 2'd2;
            rsp_out.data[0] = RSP_OK;
            rsp_out.data[1] = mem_rdata;
        end
    end

    // ========================================================
    // Registers and strobes
    // ========================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg_q.width  <= `HL_RESET_WIDTH;
            cfg_q.height <= `HL_RESET_HEIGHT;
            cfg_q.scale  <= `HL_RESET_SCALE;
            cfg_q.simd   <= 1'b0;
            addr_q       <= '0;
            wait_rd      <= 1'b0;
            dsa_start    <= 1'b0;
            mem_write_en <= 1'b0;
            mem_read_en  <= 1'b0;
        end else begin
            dsa_start    <= 1'b0;
            mem_write_en <= 1'b0;
            mem_read_en  <= 1'b0;
            // Step past a write once the memory has seen the address
            if (mem_write_en) begin
                addr_q <= addr_q + 1'b1;
            end
            if (cmd_pop) begin
                case (cmd_in.opcode)
                    OP_SET_WIDTH:  cfg_q.width  <= {cmd_in.arg[0], cmd_in.arg[1]};
                    OP_SET_HEIGHT: cfg_q.height <= {cmd_in.arg[0], cmd_in.arg[1]};
                    OP_SET_SCALE:  cfg_q.scale  <= cmd_in.arg[0];
                    OP_SET_MODE:   cfg_q.simd   <= cmd_in.arg[0][0];
                    OP_START:      dsa_start    <= !status.busy;
                    OP_SET_ADDR:   addr_q       <= addr_arg[`HL_ADDR_WIDTH-1:0];
                    OP_WRITE_MEM:  mem_write_en <= 1'b1;
                    OP_READ_MEM: begin
                        mem_read_en <= 1'b1;
                        wait_rd     <= 1'b1;
                    end
                    default: ;
                endcase
            end
            if (rd_done) begin
                wait_rd <= 1'b0;
                addr_q  <= addr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_pop && cmd_in.opcode == OP_WRITE_MEM) begin
            mem_wdata <= cmd_in.arg[0];
        end
    end

endmodule

/* rtl/cmd_parser.sv */
/*
 * Command parser
 * Collects an opcode and its argument bytes from the receive
 * stream and pushes the finished command into the command FIFO
 */

module cmd_parser
    import host_link_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] rx_data,
    input  logic       rx_valid,
    output logic       rx_ready,
    input  logic       cmd_full,
    output logic       cmd_push,
    output cmd_t       cmd_out
);

    // Number of argument bytes that follow each opcode
    function automatic logic [1:0] arg_count(input logic [7:0] op);
        case (opcode_e'(op))
            OP_SET_WIDTH,
            OP_SET_HEIGHT: arg_count = 2'd2;
            OP_SET_SCALE,
            OP_SET_MODE,
            OP_WRITE_MEM:  arg_count = 2'd1;
            OP_SET_ADDR:   arg_count = 2'd3;
            default:       arg_count = 2'd0;
        endcase
    endfunction

    cmd_t       cmd_q;
    cmd_t       rec;
    logic       in_cmd;
    logic       pend;
    logic [1:0] need;
    logic [1:0] idx;
    logic [1:0] nargs;
    logic       last;
    logic       accept;

    assign rx_ready = !(pend && cmd_full);
    assign accept   = rx_valid && rx_ready;

    // Record as it looks after the byte on rx_data is taken
    always_comb begin
        rec   = cmd_q;
        nargs = 2'd0;
        if (!in_cmd) begin
            rec.opcode = opcode_e'(rx_data);
            rec.arg    = '0;
            nargs      = arg_count(rx_data);
            last       = (nargs == 2'd0);
        end else begin
            rec.arg[idx] = rx_data;
            last         = (idx + 2'd1 == need);
        end
    end

    // A held record goes out before anything new
    assign cmd_out  = pend ? cmd_q : rec;
    assign cmd_push = pend ? !cmd_full : (accept && last && !cmd_full);

    // ========================================================
    // Byte counting and hold flag
    // ========================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_cmd <= 1'b0;
            need   <= 2'd0;
            idx    <= 2'd0;
            pend   <= 1'b0;
        end else begin
            if (accept) begin
                if (!in_cmd) begin
                    in_cmd <= !last;
                    need   <= nargs;
                    idx    <= 2'd0;
                end else begin
                    idx <= idx + 2'd1;
                    if (last) begin
                        in_cmd <= 1'b0;
                    end
                end
            end
            // New command waits if the FIFO is full or the slot went to the held one
            if (accept && last) begin
                pend <= pend || cmd_full;
            end else if (cmd_push) begin
                pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q <= rec;
        end
    end

endmodule

/* rtl/host_link_config.svh */
/*
 * Host link configuration
 * Address width, FIFO depth and the image settings
 * loaded into the accelerator configuration at reset
 */

`ifndef HOST_LINK_CONFIG_SVH
`define HOST_LINK_CONFIG_SVH

// External memory address width in bits
`define HL_ADDR_WIDTH 18

// Entries in each of the command and response FIFOs
`define HL_FIFO_DEPTH 2

// Image configuration after reset
`define HL_RESET_WIDTH  16'd512
`define HL_RESET_HEIGHT 16'd512
`define HL_RESET_SCALE  8'h80

`endif

/* rtl/host_link_pkg.sv */
/*
 * Host link types
 * Opcodes, response codes and the records that pass
 * between parser, executor and serializer
 */

`include "host_link_config.svh"

package host_link_pkg;

    // Command opcodes as received on the byte stream
    typedef enum logic [7:0] {
        OP_NOP          = 8'h00,
        OP_SET_WIDTH    = 8'h01,
        OP_SET_HEIGHT   = 8'h02,
        OP_SET_SCALE    = 8'h03,
        OP_SET_MODE     = 8'h04,
        OP_START        = 8'h05,
        OP_GET_STATUS   = 8'h06,
        OP_GET_PROGRESS = 8'h07,
        OP_WRITE_MEM    = 8'h10,
        OP_READ_MEM     = 8'h11,
        OP_SET_ADDR     = 8'h12
    } opcode_e;

    // First byte of every response
    typedef enum logic [7:0] {
        RSP_OK    = 8'hA0,
        RSP_BUSY  = 8'hB0,
        RSP_ERROR = 8'hE0
    } rsp_code_e;

    typedef logic [`HL_ADDR_WIDTH-1:0] addr_t;

    // Opcode plus up to three argument bytes, arg[0] arrives first
    typedef struct packed {
        opcode_e         opcode;
        logic [2:0][7:0] arg;
    } cmd_t;

    // Byte count 1 to 3, data[0] goes out first
    typedef struct packed {
        logic [1:0]      count;
        logic [2:0][7:0] data;
    } rsp_t;

    typedef struct packed {
        logic [15:0] width;
        logic [15:0] height;
        logic [7:0]  scale;
        logic        simd;
    } img_cfg_t;

    typedef struct packed {
        logic        busy;
        logic        ready;
        logic [15:0] progress;
    } dsa_status_t;

endpackage

/* rtl/host_link_top.sv */
/*
 * Host link top level
 * Parser, command FIFO, executor, response FIFO and serializer
 */

module host_link_top
    import host_link_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  rx_data,
    input  logic        rx_valid,
    output logic        rx_ready,
    output logic [7:0]  tx_data,
    output logic        tx_valid,
    input  logic        tx_ready,
    output img_cfg_t    cfg,
    input  dsa_status_t status,
    output logic        dsa_start,
    output logic        mem_write_en,
    output logic        mem_read_en,
    output addr_t       mem_addr,
    output logic [7:0]  mem_wdata,
    input  logic [7:0]  mem_rdata
);

    cmd_t cmd_in;
    cmd_t cmd_head;
    logic cmd_push;
    logic cmd_pop;
    logic cmd_full;
    logic cmd_empty;

    rsp_t rsp_in;
    rsp_t rsp_head;
    logic rsp_push;
    logic rsp_pop;
    logic rsp_full;
    logic rsp_empty;

    cmd_parser u_cmd_parser (
        .clk      (clk),
        .rst      (rst),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .cmd_full (cmd_full),
        .cmd_push (cmd_push),
        .cmd_out  (cmd_in)
    );

    sync_fifo #(.entry_t(cmd_t)) u_cmd_fifo (
        .clk   (clk),
        .rst   (rst),
        .push  (cmd_push),
        .din   (cmd_in),
        .pop   (cmd_pop),
        .dout  (cmd_head),
        .full  (cmd_full),
        .empty (cmd_empty)
    );

    cmd_executor u_cmd_executor (
        .clk          (clk),
        .rst          (rst),
        .cmd_in       (cmd_head),
        .cmd_empty    (cmd_empty),
        .cmd_pop      (cmd_pop),
        .rsp_full     (rsp_full),
        .rsp_push     (rsp_push),
        .rsp_out      (rsp_in),
        .cfg          (cfg),
        .status       (status),
        .dsa_start    (dsa_start),
        .mem_write_en (mem_write_en),
        .mem_read_en  (mem_read_en),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata)
    );

    sync_fifo #(.entry_t(rsp_t)) u_rsp_fifo (
        .clk   (clk),
        .rst   (rst),
        .push  (rsp_push),
        .din   (rsp_in),
        .pop   (rsp_pop),
        .dout  (rsp_head),
        .full  (rsp_full),
        .empty (rsp_empty)
    );

    rsp_serializer u_rsp_serializer (
        .clk       (clk),
        .rst       (rst),
        .rsp_in    (rsp_head),
        .rsp_empty (rsp_empty),
        .rsp_pop   (rsp_pop),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready)
    );

endmodule

/* rtl/rsp_serializer.sv */
/*
 * Response serializer
 * Sends the bytes of each response record in order on the
 * transmit stream, honouring tx_ready back-pressure
 */

module rsp_serializer
    import host_link_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  rsp_t       rsp_in,
    input  logic       rsp_empty,
    output logic       rsp_pop,
    output logic [7:0] tx_data,
    output logic       tx_valid,
    input  logic       tx_ready
);

    rsp_t       cur;
    logic [1:0] idx;
    logic       sent;
    logic       last_sent;

    assign sent      = tx_valid && tx_ready;
    assign last_sent = sent && (idx == cur.count - 2'd1);

    // Next record loads when idle or right behind the last byte
    assign rsp_pop = !rsp_empty && (!tx_valid || last_sent);

    // Held steady by cur and idx during a stall
    assign tx_data = cur.data[idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_valid <= 1'b0;
            idx      <= 2'd0;
        end else begin
            if (rsp_pop) begin
                tx_valid <= 1'b1;
                idx      <= 2'd0;
            end else if (last_sent) begin
                tx_valid <= 1'b0;
            end else if (sent) begin
                idx <= idx + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_pop) begin
            cur <= rsp_in;
        end
    end

endmodule

/* rtl/sync_fifo.sv */
/*
 * Synchronous FIFO
 * Circular buffer whose entry type is a parameter, so the
 * same block carries commands and responses
 */

`include "host_link_config.svh"

module sync_fifo
    import host_link_pkg::*;
#(
    parameter type entry_t = cmd_t
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   push,
    input  entry_t din,
    input  logic   pop,
    output entry_t dout,
    output logic   full,
    output logic   empty
);

    localparam int DEPTH = `HL_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    entry_t             mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;

    assign dout  = mem[rd_ptr];
    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Occupancy holds when both happen together
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

endmodule
